/* logic/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [2:0] {
        KIND_NORMAL = 3'd0,
        KIND_BRANCH = 3'd1,
        KIND_EXCP   = 3'd2,
        KIND_ERTN   = 3'd3,
        KIND_IDLE   = 3'd4
    } inst_kind_t;

    // offset counts words, not bytes
    typedef struct packed {
        inst_kind_t         kind;
        logic               pred_taken;
        logic signed [27:0] offset;
    } inst_word_t;

    typedef struct packed {
        logic [31:0] pc;
        inst_word_t  inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_kind_t  kind;
        logic        mispredict;
        logic [31:0] target;
    } retire_t;

    localparam logic [31:0] RESET_PC    = 32'h1c00_0000;
    localparam logic [31:0] EXCP_VECTOR = 32'h1c00_8000;

    // taken target of a branch at pc
    function automatic logic [31:0] branch_target(input logic [31:0] pc,
                                                  input logic signed [27:0] offset);
        branch_target = pc + {{2{offset[27]}}, offset, 2'b00};
    endfunction

endpackage

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall_pc,
    input  logic                      flush_ifr,
    input  logic                      stall_ifr,
    input  logic                      redirect,
    input  logic [31:0]               redirect_pc,
    input  logic                      inst_valid,
    input  core_ctrl_pkg::inst_word_t inst,
    output logic [31:0]               fetch_pc,
    output logic                      fetch_en,
    output logic                      jump,
    output logic                      pkt_valid,
    output core_ctrl_pkg::fetch_pkt_t pkt
);

    logic [31:0] pc;
    logic [31:0] resp_pc;
    logic        resp_pend;
    logic        ifr_valid;
    logic        capture;
    logic        rewind;
    logic [31:0] jump_target;

    assign fetch_pc = pc;
    assign fetch_en = !stall_pc;

    // fetch register leaves for the queue unless held
    assign pkt_valid = ifr_valid && !stall_ifr;

    // predicted-taken branch steers fetch early
    assign jump = pkt_valid && !redirect
                  && (pkt.inst.kind == core_ctrl_pkg::KIND_BRANCH)
                  && pkt.inst.pred_taken;
    assign jump_target = core_ctrl_pkg::branch_target(pkt.pc, pkt.inst.offset);

    assign capture = resp_pend && inst_valid && !flush_ifr && !stall_ifr;

    // response was owed but dropped, so fetch that address again
    assign rewind = resp_pend && !capture && !redirect && !jump;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc        <= core_ctrl_pkg::RESET_PC;
            resp_pend <= 1'b0;
            ifr_valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (jump) begin
                pc <= jump_target;
            end else if (rewind) begin
                pc <= resp_pc;
            end else if (!stall_pc) begin
                pc <= pc + 32'd4;
            end
            resp_pend <= fetch_en && !redirect && !jump && !rewind;
            if (redirect) begin
                ifr_valid <= 1'b0;
            end else if (!stall_ifr) begin
                ifr_valid <= capture;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            resp_pc <= pc;
        end
        if (capture) begin
            pkt.pc   <= resp_pc;
            pkt.inst <= inst;
        end
    end

endmodule

`default_nettype wire

/* logic/inst_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_queue #(
    parameter  int IQ_DEPTH = 4,
    localparam int PTR_W    = $clog2(IQ_DEPTH)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  core_ctrl_pkg::fetch_pkt_t push_pkt,
    input  logic                      pop_ready,
    input  logic                      flush,
    input  logic                      stall,
    output logic                      pop_valid,
    output core_ctrl_pkg::fetch_pkt_t pop_pkt,
    output logic                      full
);

    core_ctrl_pkg::fetch_pkt_t mem [IQ_DEPTH];

    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [PTR_W:0]   count;
    logic             push_fire;
    logic             pop_fire;

    // one slot kept spare for the word in the fetch register
    assign full      = (count >= (PTR_W + 1)'(IQ_DEPTH - 1));
    assign push_fire = push && (count != (PTR_W + 1)'(IQ_DEPTH));
    assign pop_valid = (count != '0) && !stall && !flush;
    assign pop_fire  = pop_valid && pop_ready;
    assign pop_pkt   = mem[rptr];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (flush) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push_fire) begin
                wptr <= wptr + 1'b1;
            end
            if (pop_fire) begin
                rptr <= rptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(push_fire) - (PTR_W + 1)'(pop_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wptr] <= push_pkt;
        end
    end

endmodule

`default_nettype wire

/* logic/reorder_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer #(
    parameter  int ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_valid,
    input  core_ctrl_pkg::fetch_pkt_t alloc_pkt,
    input  logic                      wb_valid,
    input  logic [TAG_W-1:0]          wb_tag,
    input  logic                      wb_taken,
    input  logic                      flush,
    output logic [TAG_W-1:0]          alloc_tag,
    output logic                      full,
    output core_ctrl_pkg::retire_t    retire
);

    core_ctrl_pkg::fetch_pkt_t pkt_q [ROB_DEPTH];

    logic [ROB_DEPTH-1:0]      done_q;
    logic [ROB_DEPTH-1:0]      taken_q;
    logic [TAG_W-1:0]          head;
    logic [TAG_W-1:0]          tail;
    logic [TAG_W:0]            count;
    logic [31:0]               era;
    logic                      alloc_fire;
    logic                      retire_fire;
    core_ctrl_pkg::fetch_pkt_t head_pkt;
    logic                      head_taken;
    logic [31:0]               seq_pc;

    assign full       = (count == (TAG_W + 1)'(ROB_DEPTH));
    assign alloc_fire = alloc_valid && !full;
    assign alloc_tag  = tail;
    assign head_pkt   = pkt_q[head];
    assign head_taken = taken_q[head];
    assign seq_pc     = head_pkt.pc + 32'd4;

    always_comb begin
        retire.valid      = (count != '0) && done_q[head];
        retire.pc         = head_pkt.pc;
        retire.kind       = head_pkt.inst.kind;
        retire.mispredict = (head_pkt.inst.kind == core_ctrl_pkg::KIND_BRANCH)
                            && (head_taken != head_pkt.inst.pred_taken);
        case (head_pkt.inst.kind)
            core_ctrl_pkg::KIND_BRANCH: begin
                retire.target = head_taken
                              ? core_ctrl_pkg::branch_target(head_pkt.pc, head_pkt.inst.offset)
                              : seq_pc;
            end
            core_ctrl_pkg::KIND_EXCP: retire.target = core_ctrl_pkg::EXCP_VECTOR;
            core_ctrl_pkg::KIND_ERTN: retire.target = era;
            default:                  retire.target = seq_pc;
        endcase
    end

    assign retire_fire = retire.valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else if (flush) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (wb_valid) begin
                done_q[wb_tag] <= 1'b1;
            end
            // a fresh entry is never done
            if (alloc_fire) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (retire_fire) begin
                head <= head + 1'b1;
            end
            count <= count + (TAG_W + 1)'(alloc_fire) - (TAG_W + 1)'(retire_fire);
        end
    end

    // return address for ertn
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            era <= core_ctrl_pkg::RESET_PC;
        end else if (retire_fire && (retire.kind == core_ctrl_pkg::KIND_EXCP)) begin
            era <= seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            pkt_q[tail] <= alloc_pkt;
        end
        if (wb_valid) begin
            taken_q[wb_tag] <= wb_taken;
        end
    end

endmodule

`default_nettype wire

/* logic/pipe_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall_if_request,
    input  logic                   jump,
    input  logic                   full_ififo,
    input  logic                   full_rob,
    input  core_ctrl_pkg::retire_t retire,
    input  logic                   has_int,
    output logic                   flush_pc,
    output logic                   stall_pc,
    output logic                   flush_ifr,
    output logic                   stall_ifr,
    output logic                   flush_iq,
    output logic                   stall_in,
    output logic                   flush_rob
);

    logic idle_lock;
    logic flush_branch;
    logic flush_excp;
    logic flush_ertn;
    logic flush_idle;
    logic flush_back;

    // retire causes, only one can be live at a time
    assign flush_branch = retire.valid && (retire.kind == core_ctrl_pkg::KIND_BRANCH)
                          && retire.mispredict;
    assign flush_excp   = retire.valid && (retire.kind == core_ctrl_pkg::KIND_EXCP);
    assign flush_ertn   = retire.valid && (retire.kind == core_ctrl_pkg::KIND_ERTN);
    assign flush_idle   = retire.valid && (retire.kind == core_ctrl_pkg::KIND_IDLE);

    assign flush_back = flush_branch | flush_excp | flush_ertn | flush_idle;
    assign flush_pc   = flush_back;
    assign flush_iq   = flush_back;
    assign flush_rob  = flush_back;

    // rob full holds dispatch
    assign stall_in  = full_rob;

    // queue filling or bus busy holds the front
    assign stall_ifr = full_ififo;
    assign stall_pc  = full_ififo | idle_lock | stall_if_request;
    assign flush_ifr = flush_back | jump | idle_lock | stall_if_request;

    // locked after idle until an interrupt shows up
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idle_lock <= 1'b0;
        end else if (flush_idle && !has_int) begin
            idle_lock <= 1'b1;
        end else if (has_int) begin
            idle_lock <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/frontend_core.sv */
`timescale 1ns/10ps
`default_nettype none

module frontend_core #(
    parameter int IQ_DEPTH  = 4,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    output logic [31:0]                  fetch_pc,
    output logic                         fetch_en,
    input  logic                         inst_valid,
    input  core_ctrl_pkg::inst_word_t    inst,
    input  logic                         stall_if_request,
    input  logic                         wb_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] wb_tag,
    input  logic                         wb_taken,
    output logic                         disp_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] disp_tag,
    input  logic                         has_int,
    output core_ctrl_pkg::retire_t       retire
);

    logic                      flush_pc;
    logic                      stall_pc;
    logic                      flush_ifr;
    logic                      stall_ifr;
    logic                      flush_iq;
    logic                      stall_in;
    logic                      flush_rob;
    logic                      jump;
    logic                      full_ififo;
    logic                      full_rob;
    logic                      pkt_valid;
    core_ctrl_pkg::fetch_pkt_t pkt;
    core_ctrl_pkg::fetch_pkt_t disp_pkt;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst),
        .stall_pc(stall_pc), .flush_ifr(flush_ifr), .stall_ifr(stall_ifr),
        .redirect(flush_pc), .redirect_pc(retire.target),
        .inst_valid(inst_valid), .inst(inst),
        .fetch_pc(fetch_pc), .fetch_en(fetch_en), .jump(jump),
        .pkt_valid(pkt_valid), .pkt(pkt)
    );

    // dispatch is always ready, the rob holds it through stall_in
    inst_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq (
        .clk(clk), .rst(rst),
        .push(pkt_valid), .push_pkt(pkt), .pop_ready(1'b1),
        .flush(flush_iq), .stall(stall_in),
        .pop_valid(disp_valid), .pop_pkt(disp_pkt), .full(full_ififo)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk(clk), .rst(rst),
        .alloc_valid(disp_valid), .alloc_pkt(disp_pkt),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_taken(wb_taken),
        .flush(flush_rob),
        .alloc_tag(disp_tag), .full(full_rob), .retire(retire)
    );

    pipe_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .stall_if_request(stall_if_request), .jump(jump),
        .full_ififo(full_ififo), .full_rob(full_rob),
        .retire(retire), .has_int(has_int),
        .flush_pc(flush_pc), .stall_pc(stall_pc),
        .flush_ifr(flush_ifr), .stall_ifr(stall_ifr),
        .flush_iq(flush_iq), .stall_in(stall_in), .flush_rob(flush_rob)
    );

endmodule

`default_nettype wire

/* tb/frontend_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module frontend_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   flush_rob,
    input logic                   flush_iq,
    input logic                   stall_pc,
    input logic                   idle_lock,
    input core_ctrl_pkg::retire_t retire
);

    int fail_count;

    initial fail_count = 0;

    // rob comes out of a flush empty
    rob_flush_with_iq: assert property (@(posedge clk) disable iff (!rst)
        flush_rob |-> flush_iq ##1 !retire.valid)
        else begin
            $error("flush_rob without flush_iq, or a retire right after the flush");
            fail_count = fail_count + 1;
        end

    // only a flushing retire empties the rob
    rob_flush_cause: assert property (@(posedge clk) disable iff (!rst)
        flush_rob |-> retire.valid
                      && ((retire.kind != core_ctrl_pkg::KIND_NORMAL) || retire.mispredict))
        else begin
            $error("flush_rob high without a flushing retire");
            fail_count = fail_count + 1;
        end

    // nothing left to retire while locked
    idle_holds_pc: assert property (@(posedge clk) disable iff (!rst)
        idle_lock |-> stall_pc && !retire.valid)
        else begin
            $error("idle_lock set but stall_pc low or a retire seen");
            fail_count = fail_count + 1;
        end

endmodule

`default_nettype wire

/* tb/frontend_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module frontend_checker #(
    parameter  int ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [31:0]               fetch_pc,
    input  logic                      inst_valid,
    input  core_ctrl_pkg::inst_word_t inst,
    input  logic                      wb_valid,
    input  logic [TAG_W-1:0]          wb_tag,
    input  logic                      wb_taken,
    input  logic                      disp_valid,
    input  logic [TAG_W-1:0]          disp_tag,
    input  logic                      has_int,
    input  core_ctrl_pkg::retire_t    retire,
    output int                        errors,
    output int                        retires
);

    core_ctrl_pkg::inst_word_t word_at [logic [31:0]];
    core_ctrl_pkg::inst_word_t w;
    logic [TAG_W-1:0]          tags [$];
    logic [TAG_W-1:0]          head_tag;
    logic [ROB_DEPTH-1:0]      taken_at;
    logic [31:0]               exp_pc;
    logic [31:0]               era;
    logic [31:0]               req_pc;
    logic                      idle_wait;
    logic                      taken;
    logic                      flush;
    logic                      exp_mis;

    // next retired pc along the resolved path
    function automatic logic [31:0] next_retire_pc(input logic [31:0] pc,
                                                   input core_ctrl_pkg::inst_word_t inst_w,
                                                   input logic is_taken,
                                                   input logic [31:0] era_pc);
        logic [31:0] seq;
        seq = pc + 32'd4;
        case (inst_w.kind)
            core_ctrl_pkg::KIND_BRANCH: begin
                next_retire_pc = is_taken ? pc + ({{4{inst_w.offset[27]}}, inst_w.offset} << 2)
                                          : seq;
            end
            core_ctrl_pkg::KIND_EXCP: next_retire_pc = core_ctrl_pkg::EXCP_VECTOR;
            core_ctrl_pkg::KIND_ERTN: next_retire_pc = era_pc;
            default:                  next_retire_pc = seq;
        endcase
    endfunction

    function automatic logic causes_flush(input core_ctrl_pkg::inst_word_t inst_w,
                                          input logic is_taken);
        if (inst_w.kind == core_ctrl_pkg::KIND_BRANCH) begin
            return is_taken != inst_w.pred_taken;
        end
        return inst_w.kind != core_ctrl_pkg::KIND_NORMAL;
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            word_at.delete();
            tags.delete();
            exp_pc    = core_ctrl_pkg::RESET_PC;
            era       = core_ctrl_pkg::RESET_PC;
            req_pc    = '0;
            idle_wait = 1'b0;
            errors    = 0;
            retires   = 0;
        end else begin
            flush = 1'b0;
            if (retire.valid) begin
                retires = retires + 1;
                if (idle_wait) begin
                    errors = errors + 1;
                    $display("ERROR at %0t: pc %h retired while fetch should be locked by IDLE",
                             $time, retire.pc);
                end
                if (retire.pc !== exp_pc) begin
                    errors = errors + 1;
                    $display("CHECK FAILED time=%0t signal=retire.pc expected=%h actual=%h",
                             $time, exp_pc, retire.pc);
                end
                if (tags.size() == 0 || !word_at.exists(retire.pc)) begin
                    errors = errors + 1;
                    $display("ERROR at %0t: pc %h retired but was never fetched and dispatched",
                             $time, retire.pc);
                end else begin
                    head_tag = tags.pop_front();
                    w        = word_at[retire.pc];
                    taken    = taken_at[head_tag];
                    if (retire.kind !== w.kind) begin
                        errors = errors + 1;
                        $display("CHECK FAILED time=%0t signal=retire.kind expected=%0d actual=%0d",
                                 $time, w.kind, retire.kind);
                    end
                    exp_mis = (w.kind == core_ctrl_pkg::KIND_BRANCH) && (taken != w.pred_taken);
                    if (retire.mispredict !== exp_mis) begin
                        errors = errors + 1;
                        $display({"CHECK FAILED time=%0t signal=retire.mispredict",
                                  " expected=%b actual=%b"},
                                 $time, exp_mis, retire.mispredict);
                    end
                    flush  = causes_flush(w, taken);
                    exp_pc = next_retire_pc(retire.pc, w, taken, era);
                    if (retire.target !== exp_pc) begin
                        errors = errors + 1;
                        $display("CHECK FAILED time=%0t signal=retire.target expected=%h actual=%h",
                                 $time, exp_pc, retire.target);
                    end
                    if (w.kind == core_ctrl_pkg::KIND_EXCP) begin
                        era = retire.pc + 32'd4;
                    end
                    if (w.kind == core_ctrl_pkg::KIND_IDLE && !has_int) begin
                        idle_wait = 1'b1;
                    end
                end
            end
            if (has_int) begin
                idle_wait = 1'b0;
            end
            // flush empties the rob, writebacks in that cycle are lost
            if (flush) begin
                tags.delete();
            end
            if (disp_valid) begin
                tags.push_back(disp_tag);
            end
            if (wb_valid && !flush) begin
                taken_at[wb_tag] = wb_taken;
            end
            // response belongs to the previous request
            if (inst_valid) begin
                word_at[req_pc] = inst;
            end
            req_pc = fetch_pc;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_frontend_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_frontend_core;

    localparam int          IQ_DEPTH    = 4;
    localparam int          ROB_DEPTH   = 8;
    localparam int          TAG_W       = $clog2(ROB_DEPTH);
    localparam int          NUM_RETIRES = 600;
    localparam logic [31:0] SEED        = 32'h9122;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      due;
    } wb_job_t;

    logic                      clk              = 1'b0;
    logic                      rst              = 1'b0;
    logic                      inst_valid       = 1'b0;
    core_ctrl_pkg::inst_word_t inst             = '0;
    logic                      stall_if_request = 1'b0;
    logic                      wb_valid         = 1'b0;
    logic [TAG_W-1:0]          wb_tag           = '0;
    logic                      wb_taken         = 1'b0;
    logic                      has_int          = 1'b0;
    logic [31:0]               fetch_pc;
    logic                      fetch_en;
    logic                      disp_valid;
    logic [TAG_W-1:0]          disp_tag;
    core_ctrl_pkg::retire_t    retire;

    logic [31:0] rng       = SEED;
    logic [31:0] cycle     = '0;
    logic [2:0]  busy_left = '0;
    logic        flush_seen;
    wb_job_t     job;
    wb_job_t     jobs [$];
    int          pick;
    int          errors;
    int          retires;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // instruction memory, one fixed word per pc
    function automatic core_ctrl_pkg::inst_word_t inst_at(input logic [31:0] pc);
        logic [31:0]               r;
        core_ctrl_pkg::inst_word_t w;
        r = lcg_next(lcg_next(SEED ^ pc));
        if (r[31:28] < 4'd10) begin
            w.kind = core_ctrl_pkg::KIND_NORMAL;
        end else if (r[31:28] < 4'd13) begin
            w.kind = core_ctrl_pkg::KIND_BRANCH;
        end else if (r[31:28] == 4'd13) begin
            w.kind = core_ctrl_pkg::KIND_EXCP;
        end else if (r[31:28] == 4'd14) begin
            w.kind = core_ctrl_pkg::KIND_ERTN;
        end else begin
            w.kind = core_ctrl_pkg::KIND_IDLE;
        end
        w.pred_taken = r[23];
        // -8 to +7 words
        w.offset = 28'($signed({2'b00, r[27:24]}) - 6'sd8);
        return w;
    endfunction

    frontend_core #(.IQ_DEPTH(IQ_DEPTH), .ROB_DEPTH(ROB_DEPTH)) UUT (
        .clk(clk), .rst(rst),
        .fetch_pc(fetch_pc), .fetch_en(fetch_en),
        .inst_valid(inst_valid), .inst(inst), .stall_if_request(stall_if_request),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_taken(wb_taken),
        .disp_valid(disp_valid), .disp_tag(disp_tag),
        .has_int(has_int), .retire(retire)
    );

    frontend_checker #(.ROB_DEPTH(ROB_DEPTH)) u_checker (
        .clk(clk), .rst(rst),
        .fetch_pc(fetch_pc), .inst_valid(inst_valid), .inst(inst),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_taken(wb_taken),
        .disp_valid(disp_valid), .disp_tag(disp_tag),
        .has_int(has_int), .retire(retire),
        .errors(errors), .retires(retires)
    );

    bind pipe_ctrl frontend_assertions u_assertions (
        .clk(clk), .rst(rst),
        .flush_rob(flush_rob), .flush_iq(flush_iq),
        .stall_pc(stall_pc), .idle_lock(idle_lock), .retire(retire)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            cycle = cycle + 32'd1;
            rng = lcg_next(rng);
            // bus busy for 1 to 4 cycles now and then
            if (busy_left != 3'd0) begin
                busy_left = busy_left - 3'd1;
            end else if (rng[31:27] == 5'd0) begin
                busy_left = 3'(rng[26:25]) + 3'd1;
            end
            stall_if_request <= (busy_left != 3'd0);
            has_int          <= (rng[24:20] == 5'd0);
            inst_valid       <= fetch_en;
            inst             <= inst_at(fetch_pc);

            flush_seen = retire.valid && (retire.mispredict
                         || (retire.kind == core_ctrl_pkg::KIND_EXCP)
                         || (retire.kind == core_ctrl_pkg::KIND_ERTN)
                         || (retire.kind == core_ctrl_pkg::KIND_IDLE));
            if (flush_seen) begin
                jobs.delete();
                wb_valid <= 1'b0;
            end else begin
                if (disp_valid) begin
                    rng = lcg_next(rng);
                    job.tag = disp_tag;
                    // every other 256-cycle window writebacks get slow and fill the rob
                    job.due = cycle + 32'(rng[31:16] % 16'd7) + (cycle[8] ? 32'd24 : 32'd0);
                    jobs.push_back(job);
                end
                pick = -1;
                foreach (jobs[i]) begin
                    if (pick < 0 && jobs[i].due <= cycle) begin
                        pick = i;
                    end
                end
                if (pick >= 0) begin
                    rng = lcg_next(rng);
                    wb_valid <= 1'b1;
                    wb_tag   <= jobs[pick].tag;
                    wb_taken <= rng[31];
                    jobs.delete(pick);
                end else begin
                    wb_valid <= 1'b0;
                end
            end
        end
    end

    initial begin
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        wait (retires >= NUM_RETIRES);
        @(posedge clk);
        $display("closing: errors=%0d assertion_failures=%0d retires=%0d",
                 errors, UUT.u_ctrl.u_assertions.fail_count, retires);
        if (errors == 0 && UUT.u_ctrl.u_assertions.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (200 * NUM_RETIRES) @(posedge clk);
        $display("timeout: only %0d of %0d retires after %0d cycles",
                 retires, NUM_RETIRES, 200 * NUM_RETIRES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
logic/core_ctrl_pkg.sv
logic/fetch_unit.sv
logic/inst_queue.sv
logic/reorder_buffer.sv
logic/pipe_ctrl.sv
logic/frontend_core.sv
tb/frontend_assertions.sv
tb/frontend_checker.sv
tb/tb_frontend_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_frontend_core -f project.f -o sim_frontend

out=$(./obj_dir/sim_frontend +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -q "^Simulation PASSED$"
